// ==== sources.f ====
source/csr_pkg.sv
source/csr_decoder.sv
source/csr_regfile.sv
source/mcycle_counter.sv
source/trap_ctrl.sv
source/csr_unit.sv
dv/csr_assertions.sv
dv/csr_tb_clk.sv
dv/csr_tb.sv

// ==== dv/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;

    localparam int XLEN            = csr_pkg::XLEN;
    localparam int MAX_TESTS       = 64;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_TEST = 20;
    localparam logic [63:0] LCG_SEED = 64'd69796;

    // test kinds
    localparam logic [2:0] K_CSR    = 3'd0;
    localparam logic [2:0] K_EXC    = 3'd1;
    localparam logic [2:0] K_MRET   = 3'd2;
    localparam logic [2:0] K_CYCLE  = 3'd3;
    localparam logic [2:0] K_CYCLEH = 3'd4;

    typedef struct packed {
        logic [2:0]      kind;
        logic [31:0]     instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] exp_rdata;
        logic            exp_illegal;
        logic            exp_redirect;
        logic [XLEN-1:0] exp_redirect_pc;
    } test_t;

    logic            clk;
    logic            rst_n;
    logic            valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic            exception;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] csr_rdata;
    logic            illegal;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    test_t           tests [0:MAX_TESTS-1];
    int              n_tests;
    int              cur_test;
    int              test_errs;
    int              n_pass;
    int              n_fail;
    logic            table_ready;
    logic [63:0]     lcg_state;

    // reference copy of the architectural CSRs
    logic [XLEN-1:0] ref_mepc;
    logic [XLEN-1:0] ref_mtvec;
    logic [XLEN-1:0] ref_mstatus;
    logic [XLEN-1:0] ref_mcause;

    csr_tb_clk u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    csr_unit u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .exception_i   (exception),
        .cause_i       (cause),
        .csr_rdata_o   (csr_rdata),
        .illegal_o     (illegal),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    bind trap_ctrl csr_assertions u_assertions (
        .clk           (clk),
        .rst_n         (rst_n),
        .state_i       (state_q),
        .exception_i   (exception_i),
        .redirect_i    (redirect_o),
        .squash_i      (squash_o),
        .trap_enter_i  (trap_enter_o),
        .trap_return_i (trap_return_o)
    );

    function logic [63:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state;
    endfunction

    // register form, rs1 = x1, rd = x2
    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr);
        return {addr, 5'd1, f3, 5'd2, 7'b1110011};
    endfunction

    function automatic logic [11:0] addr_of(input int i);
        case (i)
            0:       return 12'h341;
            1:       return 12'h305;
            2:       return 12'h300;
            default: return 12'h342;
        endcase
    endfunction

    function automatic logic [2:0] f3_of(input int j);
        case (j)
            0:       return 3'b001;
            1:       return 3'b010;
            default: return 3'b011;
        endcase
    endfunction

    function logic [XLEN-1:0] ref_read(input logic [11:0] addr);
        case (addr)
            12'h341: return ref_mepc;
            12'h305: return ref_mtvec;
            12'h300: return ref_mstatus;
            12'h342: return ref_mcause;
            default: return '0;
        endcase
    endfunction

    function void add_test(input logic [2:0] kind, input logic [31:0] i_word,
                           input logic [XLEN-1:0] pc_val, input logic [XLEN-1:0] rs1_val,
                           input logic [XLEN-1:0] cause_val, input logic [XLEN-1:0] rdata,
                           input logic ill, input logic redir, input logic [XLEN-1:0] rpc);
        tests[n_tests] = {kind, i_word, pc_val, rs1_val, cause_val, rdata, ill, redir, rpc};
        n_tests++;
    endfunction

    // apply the CSR rule to the reference copy and record the old value
    function void add_csr(input logic [2:0] f3, input logic [11:0] addr,
                          input logic [XLEN-1:0] wdata);
        logic [XLEN-1:0] old_val;
        logic [XLEN-1:0] new_val;
        logic            listed;
        listed  = (addr == 12'h341) || (addr == 12'h305) || (addr == 12'h300)
               || (addr == 12'h342);
        old_val = ref_read(addr);
        case (f3)
            3'b001:  new_val = wdata;
            3'b010:  new_val = old_val | wdata;
            default: new_val = old_val & ~wdata;
        endcase
        case (addr)
            12'h341: ref_mepc    = {new_val[XLEN-1:2], 2'b00};
            12'h305: ref_mtvec   = {new_val[XLEN-1:2], 2'b00};
            12'h300: ref_mstatus = new_val;
            12'h342: ref_mcause  = new_val;
            default: ;
        endcase
        add_test(K_CSR, csr_instr(f3, addr), '0, wdata, '0, old_val, ~listed, 1'b0, '0);
    endfunction

    function void build_table();
        logic [XLEN-1:0] exc_pc;
        logic [XLEN-1:0] exc_cause;
        logic [XLEN-1:0] redir_pc;
        ref_mepc    = '0;
        ref_mtvec   = '0;
        ref_mstatus = csr_pkg::MSTATUS_RESET;
        ref_mcause  = '0;
        n_tests     = 0;
        // reset values
        for (int i = 0; i < 4; i++) add_csr(3'b010, addr_of(i), '0);
        // each op with random data, then read back
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 3; j++) begin
                add_csr(f3_of(j), addr_of(i), lcg_next());
                add_csr(3'b010, addr_of(i), '0);
            end
        end
        // MIE = 1, MPIE = 0 before the trap
        add_csr(3'b010, 12'h300, 64'h1 << csr_pkg::MSTATUS_MIE_BIT);
        add_csr(3'b011, 12'h300, 64'h1 << csr_pkg::MSTATUS_MPIE_BIT);
        // unlisted addresses
        add_csr(3'b001, 12'h344, lcg_next());
        add_csr(3'b010, 12'h7C0, lcg_next());
        for (int i = 0; i < 4; i++) add_csr(3'b010, addr_of(i), '0);
        // exception, with a CSR write offered during the redirect cycle
        exc_pc    = lcg_next();
        exc_cause = lcg_next();
        redir_pc  = {ref_mtvec[XLEN-1:2], 2'b00};
        ref_mepc  = {exc_pc[XLEN-1:2], 2'b00};
        ref_mcause = exc_cause;
        ref_mstatus[csr_pkg::MSTATUS_MPIE_BIT] = ref_mstatus[csr_pkg::MSTATUS_MIE_BIT];
        ref_mstatus[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
        add_test(K_EXC, csr_instr(3'b001, 12'h342), exc_pc, lcg_next(), exc_cause,
                 '0, 1'b0, 1'b1, redir_pc);
        add_csr(3'b010, 12'h341, '0);
        add_csr(3'b010, 12'h342, '0);
        add_csr(3'b010, 12'h300, '0);
        // MRET back to mepc
        redir_pc = ref_mepc;
        ref_mstatus[csr_pkg::MSTATUS_MIE_BIT]  = ref_mstatus[csr_pkg::MSTATUS_MPIE_BIT];
        ref_mstatus[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
        add_test(K_MRET, 32'h3020_0073, '0, '0, '0, '0, 1'b0, 1'b1, redir_pc);
        add_csr(3'b010, 12'h300, '0);
        // cycle counter, exp_rdata holds the distance between the reads
        add_test(K_CYCLE, csr_instr(3'b010, 12'hB00), '0, '0, '0, 64'd5, 1'b0, 1'b0, '0);
        add_test(K_CYCLE, csr_instr(3'b010, 12'hB00), '0, '0, '0, 64'd13, 1'b0, 1'b0, '0);
        add_test(K_CYCLEH, csr_instr(3'b001, 12'hB80), '0, lcg_next(), '0, '0, 1'b0, 1'b0, '0);
    endfunction

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            K_CSR:   return "csr op";
            K_EXC:   return "exception";
            K_MRET:  return "mret";
            K_CYCLE: return "mcycle pair";
            default: return "mcycleh write";
        endcase
    endfunction

    task automatic check_val(input string sig, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch test %0d %s: got 0x%h, expected 0x%h", cur_test, sig, got, exp);
            test_errs++;
        end
    endtask

    task drive_instr(input logic [31:0] i_word, input logic [XLEN-1:0] rs1_val);
        @(posedge clk);
        valid     <= 1'b1;
        instr     <= i_word;
        rs1_data  <= rs1_val;
        exception <= 1'b0;
    endtask

    task drive_idle();
        @(posedge clk);
        valid     <= 1'b0;
        instr     <= '0;
        exception <= 1'b0;
    endtask

    task automatic run_test(input test_t t);
        logic [XLEN-1:0] c0;
        logic [XLEN-1:0] c1;
        case (t.kind)
            K_CSR: begin
                drive_instr(t.instr, t.rs1);
                @(negedge clk);
                check_val("csr_rdata_o", csr_rdata, t.exp_rdata);
                check_val("illegal_o", illegal, t.exp_illegal);
                check_val("redirect_o", redirect, 1'b0);
            end
            K_EXC, K_MRET: begin
                if (t.kind == K_EXC) begin
                    @(posedge clk);
                    valid     <= 1'b0;
                    exception <= 1'b1;
                    pc        <= t.pc;
                    cause     <= t.cause;
                end else begin
                    drive_instr(t.instr, '0);
                end
                @(negedge clk);
                check_val("redirect_o", redirect, 1'b0);
                check_val("illegal_o", illegal, 1'b0);
                // redirect cycle, a second exception and a write must both be dropped
                drive_instr(t.instr, t.rs1);
                exception <= (t.kind == K_EXC);
                pc        <= ~t.pc;
                cause     <= ~t.cause;
                @(negedge clk);
                check_val("redirect_o", redirect, t.exp_redirect);
                check_val("redirect_pc_o", redirect_pc, t.exp_redirect_pc);
                check_val("csr_rdata_o", csr_rdata, '0);
                check_val("illegal_o", illegal, 1'b0);
            end
            K_CYCLE: begin
                drive_instr(t.instr, '0);
                @(negedge clk);
                c0 = csr_rdata;
                repeat (t.exp_rdata - 1) drive_idle();
                drive_instr(t.instr, '0);
                @(negedge clk);
                c1 = csr_rdata;
                check_val("csr_rdata_o delta", c1 - c0, t.exp_rdata);
            end
            default: begin
                drive_instr(csr_instr(3'b010, 12'hB00), '0);
                @(negedge clk);
                c0 = csr_rdata + 1;
                drive_instr(t.instr, t.rs1);
                @(negedge clk);
                check_val("csr_rdata_o", csr_rdata, {32'h0, c0[63:32]});
                // upper half loaded, lower half held on the write edge
                drive_instr(csr_instr(3'b010, 12'hB00), '0);
                @(negedge clk);
                check_val("csr_rdata_o", csr_rdata, {t.rs1[31:0], c0[31:0]});
                drive_idle();
                drive_idle();
                drive_instr(csr_instr(3'b010, 12'hB00), '0);
                @(negedge clk);
                check_val("csr_rdata_o", csr_rdata, {t.rs1[31:0], c0[31:0]} + 64'd3);
            end
        endcase
        drive_idle();
        @(negedge clk);
        check_val("redirect_o", redirect, 1'b0);
    endtask

    initial begin
        valid       = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        exception   = 1'b0;
        cause       = '0;
        n_pass      = 0;
        n_fail      = 0;
        table_ready = 1'b0;
        lcg_state   = LCG_SEED;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int k = 0; k < n_tests; k++) begin
            cur_test  = k;
            test_errs = 0;
            run_test(tests[k]);
            if (test_errs == 0) begin
                n_pass++;
                $display("test %0d (%s) passed", k, kind_name(tests[k].kind));
            end else begin
                n_fail++;
                $display("test %0d (%s) had %0d errors", k, kind_name(tests[k].kind),
                         test_errs);
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", n_tests, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog scaled by the table length
    initial begin
        wait (table_ready === 1'b1);
        repeat (n_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired at test %0d, the run did not finish in time", cur_test);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== dv/csr_tb_clk.sv ====
`timescale 1ns/1ps

module csr_tb_clk (
    output logic clk_o,
    output logic rst_n_o
);

    localparam realtime HALF_PERIOD  = 4ns;
    localparam int      RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

    // release on a rising edge, the flops still see reset on that edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== dv/csr_assertions.sv ====
`timescale 1ns/1ps

module csr_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input csr_pkg::trap_state_e state_i,
    input logic                 exception_i,
    input logic                 redirect_i,
    input logic                 squash_i,
    input logic                 trap_enter_i,
    input logic                 trap_return_i
);

    // redirect is a single-cycle pulse
    redirect_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_i |=> !redirect_i
    ) else $error("redirect_o stayed high for more than one cycle");

    // squash and redirect mark the cycle after a trap strobe, together
    squash_matches_redirect: assert property (
        @(posedge clk) disable iff (!rst_n)
        (trap_enter_i || trap_return_i) |=> (squash_i && redirect_i)
    ) else $error("squash_o and redirect_o not both raised after a trap strobe");

    // trap states last one cycle
    state_back_to_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_i != csr_pkg::ST_RUN) |=> (state_i == csr_pkg::ST_RUN)
    ) else $error("trap FSM did not return to ST_RUN");

    // an exception offered in the redirect cycle starts no new trap
    no_enter_while_squashed: assert property (
        @(posedge clk) disable iff (!rst_n)
        (squash_i && exception_i) |=> !redirect_i
    ) else $error("exception taken during a squash cycle");

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_i,
    input  logic [31:0]              instr_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic [csr_pkg::XLEN-1:0] rs1_data_i,
    input  logic                     exception_i,
    input  logic [csr_pkg::XLEN-1:0] cause_i,
    output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
    output logic                     illegal_o,
    output logic                     redirect_o,
    output logic [csr_pkg::XLEN-1:0] redirect_pc_o
);

    csr_pkg::csr_op_e         op;
    logic [11:0]              csr_addr;
    logic                     is_mret;
    logic                     squash;
    logic                     trap_enter;
    logic                     trap_return;
    logic [csr_pkg::XLEN-1:0] regfile_rdata;
    logic [csr_pkg::XLEN-1:0] cycle_rdata;
    logic [csr_pkg::XLEN-1:0] mtvec;
    logic [csr_pkg::XLEN-1:0] mepc;

    csr_decoder u_decoder (
        .instr_i    (instr_i),
        .valid_i    (valid_i),
        .squash_i   (squash),
        .op_o       (op),
        .csr_addr_o (csr_addr),
        .is_mret_o  (is_mret),
        .illegal_o  (illegal_o)
    );

    csr_regfile u_regfile (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_i          (op),
        .csr_addr_i    (csr_addr),
        .wdata_i       (rs1_data_i),
        .pc_i          (pc_i),
        .cause_i       (cause_i),
        .trap_enter_i  (trap_enter),
        .trap_return_i (trap_return),
        .rdata_o       (regfile_rdata),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

    mcycle_counter u_mcycle (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_i       (op),
        .csr_addr_i (csr_addr),
        .wdata_i    (rs1_data_i),
        .rdata_o    (cycle_rdata)
    );

    trap_ctrl u_trap (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .exception_i   (exception_i),
        .is_mret_i     (is_mret),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .trap_enter_o  (trap_enter),
        .trap_return_o (trap_return),
        .squash_o      (squash),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    // at most one source addressed, the other reads zero
    assign csr_rdata_o = regfile_rdata | cycle_rdata;

endmodule

// ==== source/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_i,
    input  logic                     exception_i,
    input  logic                     is_mret_i,
    input  logic [csr_pkg::XLEN-1:0] mtvec_i,
    input  logic [csr_pkg::XLEN-1:0] mepc_i,
    output logic                     trap_enter_o,
    output logic                     trap_return_o,
    output logic                     squash_o,
    output logic                     redirect_o,
    output logic [csr_pkg::XLEN-1:0] redirect_pc_o
);

    csr_pkg::trap_state_e state_q;
    csr_pkg::trap_state_e state_d;

    logic running;

    // inputs are only honoured outside the redirect cycle
    assign running = (state_q == csr_pkg::ST_RUN);

    // exception has priority over a retiring MRET
    assign trap_enter_o  = running & exception_i;
    assign trap_return_o = running & valid_i & is_mret_i & ~exception_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            csr_pkg::ST_RUN: begin
                if (trap_enter_o) begin
                    state_d = csr_pkg::ST_ENTER;
                end else if (trap_return_o) begin
                    state_d = csr_pkg::ST_RETURN;
                end
            end
            csr_pkg::ST_ENTER:  state_d = csr_pkg::ST_RUN;
            csr_pkg::ST_RETURN: state_d = csr_pkg::ST_RUN;
            default:            state_d = csr_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= csr_pkg::ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // one redirect per trap state, fetch drops what it presented meanwhile
    assign redirect_o = ~running;
    assign squash_o   = redirect_o;

    always_comb begin
        case (state_q)
            csr_pkg::ST_ENTER:  redirect_pc_o = {mtvec_i[csr_pkg::XLEN-1:2], 2'b00};
            csr_pkg::ST_RETURN: redirect_pc_o = mepc_i;
            default:            redirect_pc_o = '0;
        endcase
    end

endmodule

// ==== source/mcycle_counter.sv ====
`timescale 1ns/1ps

module mcycle_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_pkg::csr_op_e         op_i,
    input  logic [11:0]              csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0] wdata_i,
    output logic [csr_pkg::XLEN-1:0] rdata_o
);

    logic [csr_pkg::XLEN-1:0]   count_q;
    logic                       sel_lo;
    logic                       sel_hi;
    logic                       wr_en;
    logic [csr_pkg::HALF_W-1:0] mask;
    logic [csr_pkg::HALF_W-1:0] old_half;
    logic [csr_pkg::HALF_W-1:0] new_half;

    assign sel_lo = (op_i != csr_pkg::OP_NONE) && (csr_addr_i == csr_pkg::ADDR_MCYCLE);
    assign sel_hi = (op_i != csr_pkg::OP_NONE) && (csr_addr_i == csr_pkg::ADDR_MCYCLEH);

    assign mask     = wdata_i[csr_pkg::HALF_W-1:0];
    assign old_half = sel_hi ? count_q[csr_pkg::XLEN-1:csr_pkg::HALF_W]
                             : count_q[csr_pkg::HALF_W-1:0];

    always_comb begin
        case (op_i)
            csr_pkg::OP_RW: new_half = mask;
            csr_pkg::OP_RS: new_half = old_half | mask;
            csr_pkg::OP_RC: new_half = old_half & ~mask;
            default:        new_half = old_half;
        endcase
    end

    // set/clear with an empty mask is a plain read, the count keeps running
    assign wr_en = (sel_lo | sel_hi) && ((op_i == csr_pkg::OP_RW) || (mask != '0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (wr_en && sel_hi) begin
            count_q[csr_pkg::XLEN-1:csr_pkg::HALF_W] <= new_half;
        end else if (wr_en) begin
            count_q[csr_pkg::HALF_W-1:0] <= new_half;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // mcycleh reads back zero-extended
    assign rdata_o = sel_lo ? count_q
                   : sel_hi ? {{csr_pkg::HALF_W{1'b0}}, count_q[csr_pkg::XLEN-1:csr_pkg::HALF_W]}
                   : '0;

endmodule

// ==== source/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  csr_pkg::csr_op_e         op_i,
    input  logic [11:0]              csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0] wdata_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic [csr_pkg::XLEN-1:0] cause_i,
    input  logic                     trap_enter_i,
    input  logic                     trap_return_i,
    output logic [csr_pkg::XLEN-1:0] rdata_o,
    output logic [csr_pkg::XLEN-1:0] mtvec_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o
);

    logic [csr_pkg::XLEN-1:0] mepc_q;
    logic [csr_pkg::XLEN-1:0] mtvec_q;
    logic [csr_pkg::XLEN-1:0] mstatus_q;
    logic [csr_pkg::XLEN-1:0] mcause_q;

    logic sel_mepc;
    logic sel_mtvec;
    logic sel_mstatus;
    logic sel_mcause;

    logic [csr_pkg::XLEN-1:0] old_val;
    logic [csr_pkg::XLEN-1:0] new_val;

    // one-hot select, only for an active op
    always_comb begin
        sel_mepc    = 1'b0;
        sel_mtvec   = 1'b0;
        sel_mstatus = 1'b0;
        sel_mcause  = 1'b0;
        if (op_i != csr_pkg::OP_NONE) begin
            case (csr_addr_i)
                csr_pkg::ADDR_MEPC:    sel_mepc    = 1'b1;
                csr_pkg::ADDR_MTVEC:   sel_mtvec   = 1'b1;
                csr_pkg::ADDR_MSTATUS: sel_mstatus = 1'b1;
                csr_pkg::ADDR_MCAUSE:  sel_mcause  = 1'b1;
                default: ;
            endcase
        end
    end

    // and-or mux, zero when nothing here is addressed
    assign old_val = ({csr_pkg::XLEN{sel_mepc}}    & mepc_q)
                   | ({csr_pkg::XLEN{sel_mtvec}}   & mtvec_q)
                   | ({csr_pkg::XLEN{sel_mstatus}} & mstatus_q)
                   | ({csr_pkg::XLEN{sel_mcause}}  & mcause_q);

    assign rdata_o = old_val;

    always_comb begin
        case (op_i)
            csr_pkg::OP_RW: new_val = wdata_i;
            csr_pkg::OP_RS: new_val = old_val | wdata_i;
            csr_pkg::OP_RC: new_val = old_val & ~wdata_i;
            default:        new_val = old_val;
        endcase
    end

    // mepc, low two bits stay zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (trap_enter_i) begin
            mepc_q <= {pc_i[csr_pkg::XLEN-1:2], 2'b00};
        end else if (sel_mepc) begin
            mepc_q <= {new_val[csr_pkg::XLEN-1:2], 2'b00};
        end
    end

    // mtvec, direct mode only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (sel_mtvec) begin
            mtvec_q <= {new_val[csr_pkg::XLEN-1:2], 2'b00};
        end
    end

    // mstatus: trap entry and MRET only move MIE/MPIE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= csr_pkg::MSTATUS_RESET;
        end else if (trap_enter_i) begin
            mstatus_q[csr_pkg::MSTATUS_MPIE_BIT] <= mstatus_q[csr_pkg::MSTATUS_MIE_BIT];
            mstatus_q[csr_pkg::MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (trap_return_i) begin
            mstatus_q[csr_pkg::MSTATUS_MIE_BIT]  <= mstatus_q[csr_pkg::MSTATUS_MPIE_BIT];
            mstatus_q[csr_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (sel_mstatus) begin
            mstatus_q <= new_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (trap_enter_i) begin
            mcause_q <= cause_i;
        end else if (sel_mcause) begin
            mcause_q <= new_val;
        end
    end

    // trap_ctrl builds the redirect target from these
    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

// ==== source/csr_decoder.sv ====
`timescale 1ns/1ps

module csr_decoder (
    input  logic [31:0]     instr_i,
    input  logic            valid_i,
    input  logic            squash_i,
    output csr_pkg::csr_op_e op_o,
    output logic [11:0]     csr_addr_o,
    output logic            is_mret_o,
    output logic            illegal_o
);

    logic             qualified;
    logic             is_system;
    logic             addr_known;
    csr_pkg::csr_op_e raw_op;

    // instruction only counts when presented and not in a redirect cycle
    assign qualified  = valid_i & ~squash_i;
    assign is_system  = (instr_i[6:0] == csr_pkg::OPC_SYSTEM);
    assign csr_addr_o = instr_i[31:20];

    // register forms only, immediate forms fall through to OP_NONE
    always_comb begin
        raw_op = csr_pkg::OP_NONE;
        if (qualified && is_system) begin
            case (instr_i[14:12])
                csr_pkg::F3_CSRRW: raw_op = csr_pkg::OP_RW;
                csr_pkg::F3_CSRRS: raw_op = csr_pkg::OP_RS;
                csr_pkg::F3_CSRRC: raw_op = csr_pkg::OP_RC;
                default:           raw_op = csr_pkg::OP_NONE;
            endcase
        end
    end

    always_comb begin
        case (csr_addr_o)
            csr_pkg::ADDR_MEPC,
            csr_pkg::ADDR_MTVEC,
            csr_pkg::ADDR_MSTATUS,
            csr_pkg::ADDR_MCAUSE,
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_MCYCLEH: addr_known = 1'b1;
            default:               addr_known = 1'b0;
        endcase
    end

    // unknown address: flag it and hide the op from the data blocks
    assign illegal_o = (raw_op != csr_pkg::OP_NONE) & ~addr_known;
    assign op_o      = illegal_o ? csr_pkg::OP_NONE : raw_op;

    // full 32-bit match, no partial decode
    assign is_mret_o = qualified & (instr_i == csr_pkg::MRET_INSTR);

endmodule

// ==== source/csr_pkg.sv ====
package csr_pkg;

    // datapath width of the core
    localparam int XLEN = 64;

    // each mcycle half is written separately
    localparam int HALF_W = XLEN / 2;

    // machine-mode CSR addresses
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MTVEC   = 12'h305;
    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
    localparam logic [11:0] ADDR_MCYCLE  = 12'hB00;
    localparam logic [11:0] ADDR_MCYCLEH = 12'hB80;

    // MPP = 11 (machine), UXL/SXL = 2
    localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h0000_000a_0000_1800;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // instruction fields
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [2:0]  F3_CSRRW   = 3'b001;
    localparam logic [2:0]  F3_CSRRS   = 3'b010;
    localparam logic [2:0]  F3_CSRRC   = 3'b011;
    localparam logic [31:0] MRET_INSTR = 32'h3020_0073;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_RW,
        OP_RS,
        OP_RC
    } csr_op_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_ENTER,
        ST_RETURN
    } trap_state_e;

endpackage
